/* Bender.yml */
package:
  name: text_display

sources:
  - include_dirs:
      - design
    files:
      - design/video_pkg.sv
      - design/overlay_pkg.sv
      - design/wb_video_port.sv
      - design/char_map_ram.sv
      - design/glyph_ram.sv
      - design/text_pixel_pipe.sv
      - design/overlay_slot_counter.sv
      - design/overlay_sequencer.sv
      - design/text_display_top.sv
  - target: test
    include_dirs:
      - design
      - tests
    files:
      - tests/text_display_tb.sv

/* design/char_map_ram.sv */
`timescale 1ns/1ps
`include "text_video_consts.svh"

module char_map_ram (
	input  logic                  CLK,
	// host write port
	input  logic                  a_we,
	input  video_pkg::map_addr_t  a_addr,
	input  video_pkg::map_word_t  a_data,
	// display read, overlay write
	input  logic                  b_we,
	input  video_pkg::map_addr_t  b_addr,
	input  video_pkg::map_word_t  b_data,
	output video_pkg::map_word_t  b_q
);

	video_pkg::map_word_t mem [`MAP_WORDS];

	////////////////////////////////////////
	// port A
	////////////////////////////////////////
	always @(posedge CLK) begin
		if (a_we)
			mem[a_addr] <= a_data;
	end

	////////////////////////////////////////
	// port B
	////////////////////////////////////////

	// read-first, b_q lags the address by one cycle
	always @(posedge CLK) begin
		if (b_we)
			mem[b_addr] <= b_data;
		b_q <= mem[b_addr];
	end

endmodule

/* design/glyph_ram.sv */
`timescale 1ns/1ps
`include "text_video_consts.svh"

module glyph_ram (
	input  logic                    CLK,
	input  logic                    we,
	input  video_pkg::glyph_addr_t  waddr,
	input  video_pkg::glyph_word_t  wdata,
	input  video_pkg::glyph_addr_t  raddr,
	output video_pkg::glyph_word_t  q
);

	// 64 glyphs, 4 words each
	video_pkg::glyph_word_t mem [`GLYPH_RAM_WORDS];

	always_ff @(posedge CLK) begin
		if (we)
			mem[waddr] <= wdata;  // loaded by the host at run time
		q <= mem[raddr];          // display read, one cycle
	end

endmodule

/* design/overlay_pkg.sv */
package overlay_pkg;

	// debug overlay sequencer states
	typedef enum logic [1:0] {
		OVL_IDLE,   // waiting for a blanking line
		OVL_WRITE,  // one map word per cycle
		OVL_HOLD    // done, wait for the line to end
	} overlay_state_t;

	typedef logic [2:0] ovl_slot_t;  // two slots per cpu word

	// cpu words shown on the debug page
	typedef logic [15:0] cpu_word_t;
	typedef logic [17:0] inst_word_t;

endpackage

/* design/overlay_sequencer.sv */
`timescale 1ns/1ps
`include "text_video_consts.svh"

module overlay_sequencer (
	input  logic                     CLK,
	input  logic                     rst_n,
	input  logic                     debug_en,
	input  video_pkg::pix_coord_t    pix_v,
	input  overlay_pkg::inst_word_t  inst,
	input  overlay_pkg::cpu_word_t   pc,
	input  overlay_pkg::cpu_word_t   alu_a,
	input  overlay_pkg::cpu_word_t   alu_b,
	input  overlay_pkg::ovl_slot_t   slot,
	input  logic                     last_slot,
	output logic                     cnt_clr,
	output logic                     cnt_en,
	output logic                     ovl_we,
	output video_pkg::map_addr_t     ovl_addr,
	output video_pkg::map_word_t     ovl_data
);

	overlay_pkg::overlay_state_t state, state_nx;
	overlay_pkg::inst_word_t     src;        // word shown by this slot
	video_pkg::map_addr_t        cell_base;
	video_pkg::glyph_code_t      d1, d2, d3, d4, d5;
	logic                        blanking;
	logic                        is_inst;

	assign blanking = (pix_v == '0);

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			state <= overlay_pkg::OVL_IDLE;
		else
			state <= state_nx;
	end

	always_comb begin
		state_nx = state;
		cnt_clr  = 1'b0;
		cnt_en   = 1'b0;
		case (state)
			overlay_pkg::OVL_IDLE: begin
				if (blanking && debug_en) begin
					state_nx = overlay_pkg::OVL_WRITE;
					cnt_clr  = 1'b1;  // start from slot 0
				end
			end
			overlay_pkg::OVL_WRITE: begin
				cnt_en = 1'b1;
				if (!blanking)
					state_nx = overlay_pkg::OVL_IDLE;  // line ended early
				else if (last_slot)
					state_nx = overlay_pkg::OVL_HOLD;
			end
			overlay_pkg::OVL_HOLD: begin
				if (!blanking)
					state_nx = overlay_pkg::OVL_IDLE;
			end
			default: state_nx = overlay_pkg::OVL_IDLE;
		endcase
	end

	// port B only while nothing is displayed
	assign ovl_we = (state == overlay_pkg::OVL_WRITE) && blanking;

	////////////////////////////////////////
	// slot contents
	////////////////////////////////////////
	always_comb begin
		is_inst = 1'b0;
		case (slot[2:1])
			2'd0: begin
				src       = inst;
				is_inst   = 1'b1;
				cell_base = video_pkg::map_addr_t'(`OVL_INST_CELL);
			end
			2'd1: begin
				src       = {2'b00, pc};
				cell_base = video_pkg::map_addr_t'(`OVL_PC_CELL);
			end
			2'd2: begin
				src       = {2'b00, alu_a};
				cell_base = video_pkg::map_addr_t'(`OVL_A_CELL);
			end
			default: begin
				src       = {2'b00, alu_b};
				cell_base = video_pkg::map_addr_t'(`OVL_B_CELL);
			end
		endcase
	end

	// hex digit glyph is nibble + 1, code 0 stays blank
	assign d1 = is_inst ? video_pkg::glyph_code_t'(src[17:16]) + 6'd1 : 6'd0;
	assign d2 = video_pkg::glyph_code_t'(src[15:12]) + 6'd1;
	assign d3 = video_pkg::glyph_code_t'(src[11:8]) + 6'd1;
	assign d4 = video_pkg::glyph_code_t'(src[7:4]) + 6'd1;
	assign d5 = video_pkg::glyph_code_t'(src[3:0]) + 6'd1;

	assign ovl_addr = cell_base + video_pkg::map_addr_t'(slot[0]);
	assign ovl_data = slot[0] ? {d4, d5, 6'd0} : {d1, d2, d3};  // second word ends blank

endmodule

/* design/overlay_slot_counter.sv */
`timescale 1ns/1ps
`include "text_video_consts.svh"

module overlay_slot_counter (
	input  logic                    CLK,
	input  logic                    rst_n,
	input  logic                    cnt_clr,
	input  logic                    cnt_en,
	output overlay_pkg::ovl_slot_t  slot,
	output logic                    last_slot
);

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			slot <= '0;
		end else if (cnt_clr) begin
			slot <= '0;
		end else if (cnt_en) begin
			if (last_slot)
				slot <= '0;  // wrap after the final slot
			else
				slot <= slot + 3'd1;
		end
	end

	assign last_slot = (slot == overlay_pkg::ovl_slot_t'(`OVL_SLOTS - 1));

endmodule

/* design/text_display_top.sv */
`timescale 1ns/1ps

module text_display_top (
	input  logic                     CLK,
	input  logic                     rst_n,
	// wishbone slave
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  video_pkg::wb_addr_t      wb_adr,
	input  video_pkg::map_word_t     wb_dat_w,
	output video_pkg::map_word_t     wb_dat_r,
	output logic                     wb_ack,
	// raster
	input  video_pkg::pix_coord_t    pix_h,
	input  video_pkg::pix_coord_t    pix_v,
	input  logic                     debug_en,
	// cpu words for the overlay
	input  overlay_pkg::inst_word_t  inst,
	input  overlay_pkg::cpu_word_t   pc,
	input  overlay_pkg::cpu_word_t   alu_a,
	input  overlay_pkg::cpu_word_t   alu_b,
	output video_pkg::rgb_t          rgb
);

	logic                    map_we, glyph_we;
	video_pkg::map_addr_t    host_addr;
	video_pkg::map_word_t    host_data;
	video_pkg::map_addr_t    map_raddr, map_b_addr, ovl_addr;
	video_pkg::map_word_t    map_q, ovl_data;
	video_pkg::glyph_addr_t  glyph_raddr;
	video_pkg::glyph_word_t  glyph_q;
	overlay_pkg::ovl_slot_t  slot;
	logic                    last_slot, cnt_clr, cnt_en, ovl_we;

	wb_video_port wb_video_port_i (
		.CLK(CLK), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.map_we(map_we), .glyph_we(glyph_we),
		.host_addr(host_addr), .host_data(host_data)
	);

	// overlay owns port B during its writes
	assign map_b_addr = ovl_we ? ovl_addr : map_raddr;

	char_map_ram char_map_ram_i (
		.CLK(CLK),
		.a_we(map_we), .a_addr(host_addr), .a_data(host_data),
		.b_we(ovl_we), .b_addr(map_b_addr), .b_data(ovl_data), .b_q(map_q)
	);

	glyph_ram glyph_ram_i (
		.CLK(CLK),
		.we(glyph_we), .waddr(host_addr[7:0]), .wdata(host_data),
		.raddr(glyph_raddr), .q(glyph_q)
	);

	text_pixel_pipe text_pixel_pipe_i (
		.CLK(CLK), .rst_n(rst_n),
		.pix_h(pix_h), .pix_v(pix_v), .debug_en(debug_en),
		.map_raddr(map_raddr), .map_q(map_q),
		.glyph_raddr(glyph_raddr), .glyph_q(glyph_q),
		.rgb(rgb)
	);

	overlay_slot_counter overlay_slot_counter_i (
		.CLK(CLK), .rst_n(rst_n),
		.cnt_clr(cnt_clr), .cnt_en(cnt_en),
		.slot(slot), .last_slot(last_slot)
	);

	overlay_sequencer overlay_sequencer_i (
		.CLK(CLK), .rst_n(rst_n),
		.debug_en(debug_en), .pix_v(pix_v),
		.inst(inst), .pc(pc), .alu_a(alu_a), .alu_b(alu_b),
		.slot(slot), .last_slot(last_slot),
		.cnt_clr(cnt_clr), .cnt_en(cnt_en),
		.ovl_we(ovl_we), .ovl_addr(ovl_addr), .ovl_data(ovl_data)
	);

endmodule

/* design/text_pixel_pipe.sv */
`timescale 1ns/1ps
`include "text_video_consts.svh"

module text_pixel_pipe (
	input  logic                    CLK,
	input  logic                    rst_n,
	input  video_pkg::pix_coord_t   pix_h,
	input  video_pkg::pix_coord_t   pix_v,
	input  logic                    debug_en,
	output video_pkg::map_addr_t    map_raddr,
	input  video_pkg::map_word_t    map_q,
	output video_pkg::glyph_addr_t  glyph_raddr,
	input  video_pkg::glyph_word_t  glyph_q,
	output video_pkg::rgb_t         rgb
);

	video_pkg::pix_coord_t h0, v0;    // 0-based coordinates
	video_pkg::map_addr_t  page_base;
	video_pkg::glyph_code_t code;

	logic       s1_blank, s2_blank;
	logic [1:0] s1_field;             // code within the map word
	logic [2:0] s1_col, s1_row;       // position inside the cell
	logic [3:0] s2_bit;               // row parity and column

	////////////////////////////////////////
	// stage 1, map address
	////////////////////////////////////////
	always_comb begin
		h0 = pix_h - 10'd1;  // wraps on blanking, masked by s1_blank
		v0 = pix_v - 10'd1;
		page_base = debug_en ? video_pkg::map_addr_t'(`PAGE0_BASE)
			: video_pkg::map_addr_t'(`PAGE1_BASE);
		map_raddr = page_base
			+ video_pkg::map_addr_t'((v0 / `CELL_PIX) * `WORDS_PER_ROW)
			+ video_pkg::map_addr_t'(h0 / (`CELL_PIX * `CODES_PER_WORD));
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			s1_blank <= 1'b1;
		else
			s1_blank <= (pix_h == '0) || (pix_v == '0);
	end

	always_ff @(posedge CLK) begin
		s1_field <= 2'((h0 % (`CELL_PIX * `CODES_PER_WORD)) / `CELL_PIX);
		s1_col   <= 3'(h0 % `CELL_PIX);
		s1_row   <= 3'(v0 % `CELL_PIX);
	end

	////////////////////////////////////////
	// stage 2, glyph address
	////////////////////////////////////////
	always_comb begin
		case (s1_field)
			2'd0:    code = map_q[17:12];  // leftmost character
			2'd1:    code = map_q[11:6];
			2'd2:    code = map_q[5:0];
			default: code = '0;
		endcase
		glyph_raddr = video_pkg::glyph_addr_t'(code * `GLYPH_WORDS + s1_row[2:1]);
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			s2_blank <= 1'b1;
		else
			s2_blank <= s1_blank;
	end

	always_ff @(posedge CLK) begin
		s2_bit <= {s1_row[0], s1_col};  // odd rows sit in the low byte
	end

	// output stage, msb is the left pixel
	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n)
			rgb <= '0;
		else if (!s2_blank && glyph_q[4'd15 - s2_bit])
			rgb <= 8'hFF;
		else
			rgb <= 8'h00;
	end

endmodule

/* design/text_video_consts.svh */
`ifndef TEXT_VIDEO_CONSTS_SVH
`define TEXT_VIDEO_CONSTS_SVH

////////////////////////////////////////
// screen geometry
////////////////////////////////////////
`define SCREEN_COLS      80
`define SCREEN_ROWS      60
`define CELL_PIX         8     // glyph cell is square
`define CODES_PER_WORD   3
`define WORDS_PER_ROW    27    // 81 codes, the last one is never shown

// character map layout
`define MAP_WORDS        4096
`define PAGE0_BASE       0     // debug page
`define PAGE1_BASE       1620  // normal page

// glyph table, two pixel rows per word
`define GLYPH_RAM_WORDS  256
`define GLYPH_WORDS      4

// host window, bit set selects the glyph table
`define WB_GLYPH_SEL_BIT 12

// overlay cells, each is the first of two map words
`define OVL_SLOTS        8
`define OVL_INST_CELL    65
`define OVL_PC_CELL      58
`define OVL_A_CELL       96
`define OVL_B_CELL       123

`endif

/* design/video_pkg.sv */
package video_pkg;

	////////////////////////////////////////
	// display side
	////////////////////////////////////////

	// 1-based raster counter, 0 means blanking
	typedef logic [9:0] pix_coord_t;

	typedef logic [7:0] rgb_t;

	////////////////////////////////////////
	// memories
	////////////////////////////////////////

	typedef logic [11:0] map_addr_t;
	typedef logic [17:0] map_word_t;    // three glyph codes, first code on top

	typedef logic [5:0] glyph_code_t;   // code 0 is blank
	typedef logic [7:0] glyph_addr_t;   // code * 4 + row pair
	typedef logic [17:0] glyph_word_t;  // two pixel rows in bits 15:0

	// host address, bit 12 picks the glyph table
	typedef logic [12:0] wb_addr_t;

endpackage

/* design/wb_video_port.sv */
`timescale 1ns/1ps
`include "text_video_consts.svh"

module wb_video_port (
	input  logic                  CLK,
	input  logic                  rst_n,
	input  logic                  wb_cyc,
	input  logic                  wb_stb,
	input  logic                  wb_we,
	input  video_pkg::wb_addr_t   wb_adr,
	input  video_pkg::map_word_t  wb_dat_w,
	output video_pkg::map_word_t  wb_dat_r,
	output logic                  wb_ack,
	output logic                  map_we,
	output logic                  glyph_we,
	output video_pkg::map_addr_t  host_addr,
	output video_pkg::map_word_t  host_data
);

	logic stb_seen;  // ack already given for this strobe

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack   <= 1'b0;
			stb_seen <= 1'b0;
		end else begin
			wb_ack <= wb_cyc && wb_stb && !stb_seen;
			if (!wb_stb)
				stb_seen <= 1'b0;  // rearm once stb drops
			else if (wb_cyc)
				stb_seen <= 1'b1;
		end
	end

	// host holds its inputs until ack, so write on the acked edge
	assign map_we   = wb_ack && wb_we && !wb_adr[`WB_GLYPH_SEL_BIT];
	assign glyph_we = wb_ack && wb_we && wb_adr[`WB_GLYPH_SEL_BIT];

	assign host_addr = wb_adr[11:0];  // glyph RAM takes the low 8 bits
	assign host_data = wb_dat_w;
	assign wb_dat_r  = '0;             // write-only port

endmodule

/* sources.f */
+incdir+design
+incdir+tests
design/video_pkg.sv
design/overlay_pkg.sv
design/wb_video_port.sv
design/char_map_ram.sv
design/glyph_ram.sv
design/text_pixel_pipe.sv
design/overlay_slot_counter.sv
design/overlay_sequencer.sv
design/text_display_top.sv
tests/text_display_tb.sv

/* tests/text_display_tasks.svh */
	////////////////////////////////////////
	// wishbone host
	////////////////////////////////////////

	// one classic cycle with inputs held until the acked edge has passed
	task automatic wb_cycle(input logic we, input logic [12:0] adr, input logic [17:0] dat);
		int n;
		n = 0;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = dat;
		do begin
			@(posedge CLK);
			#10;
			n++;
		end while (!wb_ack && n < ACK_TIMEOUT);
		if (!wb_ack) begin
			$display("timeout, no wishbone ack within %0d cycles", ACK_TIMEOUT);
			timeouts++;
		end
		check_value("ack latency", n, 1);
		if (!we)
			check_value("read data", wb_dat_r, 0);
		@(posedge CLK);  // write lands here
		#10;
		check_value("ack width", wb_ack, 0);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(posedge CLK);  // stb low for a cycle before the next transfer
		#10;
	endtask

	task automatic write_map(input int addr, input logic [17:0] data);
		wb_cycle(1'b1, 13'(addr), data);
		map_mdl[addr] = data;
	endtask

	// every map word gets codes 1 to 16 from the nibbles of its own address
	task automatic fill_map();
		logic [11:0] adr;
		for (int a = 0; a < `MAP_WORDS; a++) begin
			adr = 12'(a);
			write_map(a, {6'(adr[11:8]) + 6'd1, 6'(adr[7:4]) + 6'd1, 6'(adr[3:0]) + 6'd1});
		end
	endtask

	// blank glyph 0 and random glyphs 1 to 16
	task automatic load_glyphs();
		logic [17:0] pattern;
		for (int a = 0; a < 17 * `GLYPH_WORDS; a++) begin
			pattern = (a < `GLYPH_WORDS) ? 18'd0 : 18'(random_bits(18));
			wb_cycle(1'b1, 13'h1000 | 13'(a), pattern);
			glyph_mdl[a] = pattern;
		end
	endtask

	function automatic logic [5:0] random_code();
		return 6'(random_bits(4)) + 6'd1;
	endfunction

	////////////////////////////////////////
	// pixel scan
	////////////////////////////////////////

	function automatic logic [7:0] predict_rgb(input int h, input int v, input logic dbg);
		int addr;
		int field;
		logic [17:0] word;
		logic [5:0] code;
		logic [17:0] pattern;
		if (h == 0 || v == 0)
			return 8'h00;
		addr = (dbg ? 0 : `PAGE1_BASE) + ((v - 1) / `CELL_PIX) * `WORDS_PER_ROW
			+ (h - 1) / WORD_PIX;
		word = map_mdl[addr];
		field = ((h - 1) % WORD_PIX) / `CELL_PIX;  // 0 is the top field
		code = word[17 - 6 * field -: 6];
		pattern = glyph_mdl[code * `GLYPH_WORDS + ((v - 1) % `CELL_PIX) / 2];
		return pattern[15 - ((h - 1) % `CELL_PIX + ((v - 1) % 2) * 8)] ? 8'hFF : 8'h00;
	endfunction

	// rgb for a coordinate shows three drive points later
	task automatic step_pixel(input logic [9:0] h, input logic [9:0] v);
		logic [7:0] expected;
		if (exp_q.size() == 3) begin
			expected = exp_q.pop_front();
			check_value("rgb", rgb, expected);
		end
		pix_h = h;
		pix_v = v;
		exp_q.push_back(predict_rgb(h, v, debug_en));
		@(posedge CLK);
		#10;
	endtask

	task automatic drain_pixels();
		repeat (3)
			step_pixel(10'd0, 10'd1);  // blank with pix_v kept off 0
		exp_q.delete();
	endtask

	// every pixel of one map word indexed from the shown page's base
	task automatic scan_map_word(input int idx);
		int h0, v0;
		h0 = (idx % `WORDS_PER_ROW) * WORD_PIX;
		v0 = (idx / `WORDS_PER_ROW) * `CELL_PIX;
		for (int v = v0 + 1; v <= v0 + `CELL_PIX; v++) begin
			for (int h = h0 + 1; h <= h0 + WORD_PIX && h <= `SCREEN_COLS * `CELL_PIX; h++)
				step_pixel(10'(h), 10'(v));
		end
		drain_pixels();
	endtask

	////////////////////////////////////////
	// debug overlay
	////////////////////////////////////////

	task automatic blank_line(input int cycles);
		pix_h = 10'd0;
		pix_v = 10'd0;
		repeat (cycles) @(posedge CLK);
		#10;
		pix_v = 10'd1;
	endtask

	// digit code is nibble + 1 while code 0 stays blank
	function automatic logic [17:0] overlay_word(input logic [17:0] w, input logic is_inst,
		input logic second);
		logic [5:0] d1;
		d1 = is_inst ? 6'(w[17:16]) + 6'd1 : 6'd0;
		if (second)
			return {6'(w[7:4]) + 6'd1, 6'(w[3:0]) + 6'd1, 6'd0};
		return {d1, 6'(w[15:12]) + 6'd1, 6'(w[11:8]) + 6'd1};
	endfunction

	task automatic expect_overlay();
		map_mdl[`OVL_INST_CELL]     = overlay_word(inst, 1'b1, 1'b0);
		map_mdl[`OVL_INST_CELL + 1] = overlay_word(inst, 1'b1, 1'b1);
		map_mdl[`OVL_PC_CELL]       = overlay_word({2'b00, pc}, 1'b0, 1'b0);
		map_mdl[`OVL_PC_CELL + 1]   = overlay_word({2'b00, pc}, 1'b0, 1'b1);
		map_mdl[`OVL_A_CELL]        = overlay_word({2'b00, alu_a}, 1'b0, 1'b0);
		map_mdl[`OVL_A_CELL + 1]    = overlay_word({2'b00, alu_a}, 1'b0, 1'b1);
		map_mdl[`OVL_B_CELL]        = overlay_word({2'b00, alu_b}, 1'b0, 1'b0);
		map_mdl[`OVL_B_CELL + 1]    = overlay_word({2'b00, alu_b}, 1'b0, 1'b1);
	endtask

	task automatic scan_overlay_cells();
		int cells [4];
		cells[0] = `OVL_INST_CELL;
		cells[1] = `OVL_PC_CELL;
		cells[2] = `OVL_A_CELL;
		cells[3] = `OVL_B_CELL;
		foreach (cells[i]) begin
			scan_map_word(cells[i]);
			scan_map_word(cells[i] + 1);
		end
	endtask

/* tests/text_display_tb.sv */
`timescale 1ns/1ps
`include "text_video_consts.svh"

module text_display_tb;

	localparam int ACK_TIMEOUT = 20;  // cycles
	localparam int WORD_PIX = `CELL_PIX * `CODES_PER_WORD;

	logic                     CLK;
	logic                     rst_n;
	logic                     wb_cyc, wb_stb, wb_we;
	video_pkg::wb_addr_t      wb_adr;
	video_pkg::map_word_t     wb_dat_w, wb_dat_r;
	logic                     wb_ack;
	video_pkg::pix_coord_t    pix_h, pix_v;
	logic                     debug_en;
	overlay_pkg::inst_word_t  inst;
	overlay_pkg::cpu_word_t   pc, alu_a, alu_b;
	video_pkg::rgb_t          rgb;

	// reference copies of both memories
	logic [17:0] glyph_mdl [`GLYPH_RAM_WORDS];
	logic [17:0] map_mdl [`MAP_WORDS];
	logic [7:0]  exp_q [$];  // predicted rgb still in flight

	logic [31:0] lfsr_state;
	int          checks, errors, timeouts;

	text_display_top text_display_top_i (
		.CLK(CLK), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.pix_h(pix_h), .pix_v(pix_v), .debug_en(debug_en),
		.inst(inst), .pc(pc), .alu_a(alu_a), .alu_b(alu_b),
		.rgb(rgb)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	////////////////////////////////////////
	// random source and compare
	////////////////////////////////////////

	// galois lfsr on x^32 + x^22 + x^2 + x + 1 stepped once per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			if (lfsr_state[0])
				lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
			else
				lfsr_state = lfsr_state >> 1;
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("error at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	`include "text_display_tasks.svh"

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	// every glyph write checks the ack timing and a read must not land
	task automatic wishbone_handshake();
		load_glyphs();
		wb_cycle(1'b0, 13'h1004, 18'h3FFFF);  // glyph 1, row pair 0
	endtask

	task automatic normal_page_scan();
		int words [3];  // page-relative map words
		logic [17:0] w;
		debug_en = 1'b0;
		words[0] = 0;
		words[1] = 5 * `WORDS_PER_ROW + 13;
		words[2] = 59 * `WORDS_PER_ROW + 26;  // bottom right word with its third code off screen
		foreach (words[i]) begin
			w = {random_code(), random_code(), random_code()};
			if (i == 0)
				w[17:12] = 6'd1;  // shows the glyph the read aimed at
			write_map(`PAGE1_BASE + words[i], w);
		end
		wb_cycle(1'b0, 13'(`PAGE1_BASE), 18'h2AAAA);
		foreach (words[i])
			scan_map_word(words[i]);
	endtask

	task automatic blanking_pixels();
		debug_en = 1'b0;
		for (int v = 1; v <= 2 * `CELL_PIX; v++)
			step_pixel(10'd0, 10'(v));  // left blank column over two cell rows
		for (int h = 1; h <= WORD_PIX; h++)
			step_pixel(10'(h), 10'd0);  // blank line across one map word
		step_pixel(10'd0, 10'd3);
		step_pixel(10'd5, 10'd3);
		step_pixel(10'd5, 10'd0);
		step_pixel(10'd0, 10'd0);
		step_pixel(10'd640, 10'd0);
		step_pixel(10'd12, 10'd8);
		step_pixel(10'd0, 10'd480);
		drain_pixels();
	endtask

	task automatic debug_overlay();
		debug_en = 1'b1;
		inst  = 18'(random_bits(18));
		pc    = 16'(random_bits(16));
		alu_a = 16'(random_bits(16));
		alu_b = 16'(random_bits(16));
		blank_line(12);
		expect_overlay();
		scan_overlay_cells();
	endtask

	// overlay stays off with debug_en low so page 0 keeps its digits
	task automatic page_select();
		debug_en = 1'b0;
		inst  = ~inst;
		pc    = ~pc;
		alu_a = ~alu_a;
		alu_b = ~alu_b;
		blank_line(12);
		scan_map_word(0);
		scan_map_word(59 * `WORDS_PER_ROW + 26);
		debug_en = 1'b1;
		scan_overlay_cells();
		debug_en = 1'b0;
	endtask

	initial begin
		rst_n      = 1'b0;
		wb_cyc     = 1'b0;
		wb_stb     = 1'b0;
		wb_we      = 1'b0;
		wb_adr     = '0;
		wb_dat_w   = '0;
		pix_h      = 10'd0;
		pix_v      = 10'd1;  // blank without starting the overlay
		debug_en   = 1'b0;
		inst       = '0;
		pc         = '0;
		alu_a      = '0;
		alu_b      = '0;
		lfsr_state = 32'd70364;
		checks     = 0;
		errors     = 0;
		timeouts   = 0;
		repeat (5) @(posedge CLK);
		#10;
		rst_n = 1'b1;
		check_value("rgb after reset", rgb, 0);
		check_value("ack after reset", wb_ack, 0);

		wishbone_handshake();
		fill_map();
		normal_page_scan();
		blanking_pixels();
		debug_overlay();
		page_select();

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule
